// ==== hdl/crossbar_pkg.sv ====
package crossbar_pkg;

	//////////////////////////////
	// Trigger channels

	localparam int NUM_TRIG_IN = 12;
	localparam int NUM_TRIG_OUT = 12;

	//One bit per channel, same width on input and output side
	typedef logic [NUM_TRIG_IN-1:0] trig_vec_t;

	//Inputs with P/N swapped on the PCB for layout reasons
	localparam trig_vec_t TRIG_POLARITY_DEFAULT = 12'h065;

	//////////////////////////////
	// Output selects

	//0..11 pick an input, anything above drives the output low
	typedef logic [3:0] muxsel_t;

	localparam muxsel_t MUXSEL_OFF = 4'd15;

	//////////////////////////////
	// Relays and LEDs

	localparam int NUM_RELAYS = 4;

	typedef logic [1:0] relay_chan_t;
	typedef logic [NUM_RELAYS-1:0] relay_vec_t;

	//10 ms coil pulse at 250 MHz
	localparam int RELAY_PULSE_DEFAULT = 2500000;

	//50 ms LED hold time at 250 MHz
	localparam int LED_STRETCH_DEFAULT = 12500000;

endpackage

// ==== hdl/regmap_pkg.sv ====
package regmap_pkg;

	//////////////////////////////
	// APB bus widths

	typedef logic [7:0] apb_addr_t;
	typedef logic [31:0] apb_data_t;

	//////////////////////////////
	// Register map

	//Output k select lives at base + 4*k
	localparam apb_addr_t REG_MUXSEL_BASE = 8'h00;
	localparam int REG_MUXSEL_STRIDE = 4;

	//Write only, starts one relay pulse
	localparam apb_addr_t REG_RELAY_TOGGLE = 8'h40;

	//Toggle write fields
	localparam int TOGGLE_DIR_BIT = 0;
	localparam int TOGGLE_CHAN_LSB = 1;

	//Bit 0 is busy
	localparam apb_addr_t REG_RELAY_STATUS = 8'h44;

	//Synchronized and polarity corrected inputs
	localparam apb_addr_t REG_TRIG_STATUS = 8'h48;

endpackage

// ==== hdl/relay_cmd_if.sv ====
`timescale 1ns/1ps

interface relay_cmd_if import crossbar_pkg::*; ();

	//Single cycle start strobe plus its arguments
	logic			en;
	logic			dir;
	relay_chan_t	channel;

	//Single cycle strobe in the last pulse cycle
	logic			done;

	//Register block side
	modport ctrl(output en, output dir, output channel, input done);

	//Sequencer side
	modport relay(input en, input dir, input channel, output done);

endinterface

// ==== hdl/crossbar_matrix.sv ====
`timescale 1ns/1ps

module crossbar_matrix import crossbar_pkg::*; #(
	parameter trig_vec_t	TRIG_POLARITY = TRIG_POLARITY_DEFAULT
) (
	input wire							clk_250mhz,
	input wire							arst_n,

	//Raw pins, asynchronous to the fabric clock
	input trig_vec_t					trig_in,

	//One select per output
	input muxsel_t [NUM_TRIG_OUT-1:0]	muxsel,

	//Corrected inputs, also fed to status and LEDs
	output trig_vec_t					trig_sync,

	output trig_vec_t					trig_out
);

	//////////////////////////////
	// Two flop synchronizer

	trig_vec_t	trig_meta;
	trig_vec_t	trig_sync_ff;

	always_ff @(posedge clk_250mhz or negedge arst_n) begin
		//Idle level of each pin, so corrected inputs start low
		if (!arst_n) begin
			trig_meta		<= TRIG_POLARITY;
			trig_sync_ff	<= TRIG_POLARITY;
		end else begin
			trig_meta		<= trig_in;
			trig_sync_ff	<= trig_meta;
		end
	end

	//Undo the PCB P/N swaps
	assign trig_sync = trig_sync_ff ^ TRIG_POLARITY;

	//////////////////////////////
	// Routing

	always_ff @(posedge clk_250mhz or negedge arst_n) begin
		if (!arst_n)
			trig_out <= '0;
		else begin
			for (int k = 0; k < NUM_TRIG_OUT; k++) begin
				//Out of range select parks the output low
				if (muxsel[k] < muxsel_t'(NUM_TRIG_IN))
					trig_out[k] <= trig_sync[muxsel[k]];
				else
					trig_out[k] <= 1'b0;
			end
		end
	end

endmodule

// ==== hdl/activity_led.sv ====
`timescale 1ns/1ps

module activity_led import crossbar_pkg::*; #(
	parameter int	LED_STRETCH_CYCLES = LED_STRETCH_DEFAULT
) (
	input wire			clk_250mhz,
	input wire			arst_n,

	//Level to watch, one bit per channel
	input trig_vec_t	activity,

	output trig_vec_t	led
);

	//Wide enough to hold the full reload value
	localparam int CNT_W = $clog2(LED_STRETCH_CYCLES + 1);

	logic [CNT_W-1:0]	hold_cnt [NUM_TRIG_IN];

	//////////////////////////////
	// Per bit down counters

	always_ff @(posedge clk_250mhz or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_TRIG_IN; i++)
				hold_cnt[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_TRIG_IN; i++) begin
				//Reload as long as the bit is high
				if (activity[i])
					hold_cnt[i] <= CNT_W'(LED_STRETCH_CYCLES);
				else if (hold_cnt[i] != '0)
					hold_cnt[i] <= hold_cnt[i] - 1'b1;
			end
		end
	end

	//Lit until the hold time runs out
	always_comb begin
		for (int i = 0; i < NUM_TRIG_IN; i++)
			led[i] = (hold_cnt[i] != '0);
	end

endmodule

// ==== hdl/relay_controller.sv ====
`timescale 1ns/1ps

module relay_controller import crossbar_pkg::*; #(
	parameter int	RELAY_PULSE_CYCLES = RELAY_PULSE_DEFAULT
) (
	input wire				clk_250mhz,
	input wire				arst_n,

	relay_cmd_if.relay		cmd,

	//Two sides of each H-bridge, never both high
	output relay_vec_t		relay_a,
	output relay_vec_t		relay_b
);

	localparam int CNT_W = $clog2(RELAY_PULSE_CYCLES + 1);

	logic				active;
	logic [CNT_W-1:0]	pulse_cnt;

	//Latched command
	logic				cur_dir;
	relay_chan_t		cur_chan;

	//////////////////////////////
	// Pulse sequencer

	always_ff @(posedge clk_250mhz or negedge arst_n) begin
		if (!arst_n) begin
			active		<= 1'b0;
			pulse_cnt	<= '0;
		end else if (cmd.en) begin
			//Counts remaining cycles after the first one
			active		<= 1'b1;
			pulse_cnt	<= CNT_W'(RELAY_PULSE_CYCLES - 1);
		end else if (active) begin
			if (pulse_cnt == '0)
				active	<= 1'b0;
			else
				pulse_cnt	<= pulse_cnt - 1'b1;
		end
	end

	always_ff @(posedge clk_250mhz) begin
		if (cmd.en) begin
			cur_dir		<= cmd.dir;
			cur_chan	<= cmd.channel;
		end
	end

	//Last energized cycle
	assign cmd.done = active && (pulse_cnt == '0);

	//////////////////////////////
	// H-bridge drive

	always_comb begin
		relay_a = '0;
		relay_b = '0;
		//Direction 1 drives the A side
		if (active) begin
			if (cur_dir)
				relay_a[cur_chan] = 1'b1;
			else
				relay_b[cur_chan] = 1'b1;
		end
	end

endmodule

// ==== hdl/crossbar_regs.sv ====
`timescale 1ns/1ps

module crossbar_regs import crossbar_pkg::*, regmap_pkg::*; (
	input wire								clk_250mhz,
	input wire								arst_n,

	//APB slave, zero wait states
	input wire								psel,
	input wire								penable,
	input wire								pwrite,
	input apb_addr_t						paddr,
	input apb_data_t						pwdata,
	output apb_data_t						prdata,
	output logic							pready,
	output logic							pslverr,

	//Live corrected inputs for status readback
	input trig_vec_t						trig_sync,

	//Output selects to the matrix
	output muxsel_t [NUM_TRIG_OUT-1:0]		muxsel,

	relay_cmd_if.ctrl						relay
);

	//////////////////////////////
	// Transfer decode

	logic			access;
	logic			wr_xfer;
	logic			rd_xfer;

	apb_addr_t		mux_offset;
	logic [3:0]		mux_idx;
	logic			mux_hit;
	logic			toggle_hit;
	logic			addr_hit;
	logic			toggle_refused;

	apb_data_t		rd_value;
	logic			busy;

	//Access phase always completes in one cycle
	assign pready	= 1'b1;
	assign access	= psel && penable;
	assign wr_xfer	= access && pwrite;
	assign rd_xfer	= access && !pwrite;

	//Select window, word aligned only
	assign mux_offset	= paddr - REG_MUXSEL_BASE;
	assign mux_idx		= mux_offset[5:2];
	assign mux_hit		= (mux_offset < apb_addr_t'(REG_MUXSEL_STRIDE * NUM_TRIG_OUT)) &&
		(mux_offset[1:0] == 2'b00);

	assign toggle_hit	= (paddr == REG_RELAY_TOGGLE);

	assign addr_hit		= mux_hit || toggle_hit ||
		(paddr == REG_RELAY_STATUS) || (paddr == REG_TRIG_STATUS);

	//Relay still pulsing, command cannot be taken
	assign toggle_refused = wr_xfer && toggle_hit && busy;

	assign pslverr = access && (!addr_hit || toggle_refused);

	//////////////////////////////
	// Select registers

	always_ff @(posedge clk_250mhz or negedge arst_n) begin
		if (!arst_n) begin
			for (int k = 0; k < NUM_TRIG_OUT; k++)
				muxsel[k] <= MUXSEL_OFF;
		end else if (wr_xfer && mux_hit) begin
			for (int k = 0; k < NUM_TRIG_OUT; k++) begin
				if (mux_idx == 4'(k))
					muxsel[k] <= muxsel_t'(pwdata[3:0]);
			end
		end
	end

	//////////////////////////////
	// Relay command path

	//Fires in the access phase so the pulse starts on the next edge
	assign relay.en			= wr_xfer && toggle_hit && !busy;
	assign relay.dir		= pwdata[TOGGLE_DIR_BIT];
	assign relay.channel	= pwdata[TOGGLE_CHAN_LSB +: 2];

	//Set on issue, cleared by done
	always_ff @(posedge clk_250mhz or negedge arst_n) begin
		if (!arst_n)
			busy <= 1'b0;
		else if (relay.en)
			busy <= 1'b1;
		else if (relay.done)
			busy <= 1'b0;
	end

	//////////////////////////////
	// Readback

	always_comb begin
		rd_value = '0;
		if (mux_hit) begin
			for (int k = 0; k < NUM_TRIG_OUT; k++) begin
				if (mux_idx == 4'(k))
					rd_value = apb_data_t'(muxsel[k]);
			end
		end else if (paddr == REG_RELAY_STATUS)
			rd_value = apb_data_t'(busy);
		else if (paddr == REG_TRIG_STATUS)
			rd_value = apb_data_t'(trig_sync);
		//Toggle register and holes read as zero
	end

	assign prdata = rd_xfer ? rd_value : '0;

endmodule

// ==== hdl/trigger_crossbar_top.sv ====
`timescale 1ns/1ps

module trigger_crossbar_top import crossbar_pkg::*, regmap_pkg::*; #(
	parameter trig_vec_t	TRIG_POLARITY		= TRIG_POLARITY_DEFAULT,
	parameter int			RELAY_PULSE_CYCLES	= RELAY_PULSE_DEFAULT,
	parameter int			LED_STRETCH_CYCLES	= LED_STRETCH_DEFAULT
) (
	input wire			clk_250mhz,
	input wire			arst_n,

	//APB slave for host management
	input wire			psel,
	input wire			penable,
	input wire			pwrite,
	input apb_addr_t	paddr,
	input apb_data_t	pwdata,
	output apb_data_t	prdata,
	output logic		pready,
	output logic		pslverr,

	//Trigger ports
	input trig_vec_t	trig_in,
	output trig_vec_t	trig_out,

	//H-bridge control for relays
	output relay_vec_t	relay_a,
	output relay_vec_t	relay_b,

	//Front panel activity LEDs
	output trig_vec_t	trig_in_led,
	output trig_vec_t	trig_out_led
);

	//////////////////////////////
	// Internal wiring

	muxsel_t [NUM_TRIG_OUT-1:0]	muxsel;
	trig_vec_t					trig_sync;

	relay_cmd_if relay_cmd();

	//////////////////////////////
	// Management registers

	crossbar_regs regs(
		.clk_250mhz(clk_250mhz),
		.arst_n(arst_n),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.trig_sync(trig_sync),
		.muxsel(muxsel),
		.relay(relay_cmd)
	);

	//////////////////////////////
	// Crossbar and relays

	crossbar_matrix #(
		.TRIG_POLARITY(TRIG_POLARITY)
	) matrix (
		.clk_250mhz(clk_250mhz),
		.arst_n(arst_n),
		.trig_in(trig_in),
		.muxsel(muxsel),
		.trig_sync(trig_sync),
		.trig_out(trig_out)
	);

	relay_controller #(
		.RELAY_PULSE_CYCLES(RELAY_PULSE_CYCLES)
	) relays (
		.clk_250mhz(clk_250mhz),
		.arst_n(arst_n),
		.cmd(relay_cmd),
		.relay_a(relay_a),
		.relay_b(relay_b)
	);

	//////////////////////////////
	// LED stretchers

	//Input side watches the corrected inputs
	activity_led #(
		.LED_STRETCH_CYCLES(LED_STRETCH_CYCLES)
	) led_in (
		.clk_250mhz(clk_250mhz),
		.arst_n(arst_n),
		.activity(trig_sync),
		.led(trig_in_led)
	);

	//Output side watches the routed outputs
	activity_led #(
		.LED_STRETCH_CYCLES(LED_STRETCH_CYCLES)
	) led_out (
		.clk_250mhz(clk_250mhz),
		.arst_n(arst_n),
		.activity(trig_out),
		.led(trig_out_led)
	);

endmodule

// ==== tb/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import crossbar_pkg::*, regmap_pkg::*; #(
	parameter trig_vec_t	TRIG_POLARITY		= TRIG_POLARITY_DEFAULT,
	parameter int			RELAY_PULSE_CYCLES	= RELAY_PULSE_DEFAULT,
	parameter int			LED_STRETCH_CYCLES	= LED_STRETCH_DEFAULT
) (
	input wire			clk_250mhz,
	input wire			arst_n,

	//APB as seen on the DUT pins
	input wire			psel,
	input wire			penable,
	input wire			pwrite,
	input apb_addr_t	paddr,
	input apb_data_t	pwdata,
	input apb_data_t	prdata,
	input wire			pready,
	input wire			pslverr,

	input trig_vec_t	trig_in,
	input trig_vec_t	trig_out,
	input relay_vec_t	relay_a,
	input relay_vec_t	relay_b,
	input trig_vec_t	trig_in_led,
	input trig_vec_t	trig_out_led,

	output int			error_count
);

	//////////////////////////////
	// Reference state

	int errors = 0;

	//Selects as written by the host, then delayed to match the routing edge
	muxsel_t [NUM_TRIG_OUT-1:0]	sel_shadow;
	muxsel_t [NUM_TRIG_OUT-1:0]	sel_d1;
	muxsel_t [NUM_TRIG_OUT-1:0]	sel_d2;

	//Raw pin history, one entry per cycle
	trig_vec_t	in_d1;
	trig_vec_t	in_d2;
	trig_vec_t	in_d3;

	trig_vec_t	exp_out;
	trig_vec_t	exp_out_prev;

	//Relay pulse model
	int				relay_left;
	logic			relay_dir;
	relay_chan_t	relay_chan;

	//LED hold counters
	int	in_cnt [NUM_TRIG_IN];
	int	out_cnt [NUM_TRIG_OUT];

	assign error_count = errors;

	//Expected crossbar outputs for given raw pins and selects
	function automatic trig_vec_t route_ref(trig_vec_t raw, muxsel_t [NUM_TRIG_OUT-1:0] sel);
		trig_vec_t	fixed;
		trig_vec_t	result;
		fixed = raw ^ TRIG_POLARITY;
		result = '0;
		for (int k = 0; k < NUM_TRIG_OUT; k++) begin
			if (int'(sel[k]) < NUM_TRIG_IN)
				result[k] = fixed[sel[k]];
		end
		return result;
	endfunction

	//Output index of a select register, -1 outside the window
	function automatic int sel_index(apb_addr_t addr);
		int	offset;
		offset = int'(addr) - int'(REG_MUXSEL_BASE);
		if (offset >= 0 && offset < REG_MUXSEL_STRIDE * NUM_TRIG_OUT &&
			offset % REG_MUXSEL_STRIDE == 0)
			return offset / REG_MUXSEL_STRIDE;
		return -1;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("FAILED at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		end
	endtask

	//////////////////////////////
	// Cycle by cycle comparison

	//Negative edge, all DUT outputs and driven inputs are settled here
	always @(negedge clk_250mhz) begin : compare_proc
		logic			access;
		logic			mapped;
		logic			busy_exp;
		int				idx;
		logic [31:0]	rd_exp;
		relay_vec_t		ra_exp;
		relay_vec_t		rb_exp;
		trig_vec_t		sync_now;
		trig_vec_t		sync_prev;
		trig_vec_t		in_led_exp;
		trig_vec_t		out_led_exp;

		if (!arst_n) begin
			//Synchronizers reset to the idle pin level
			in_d1 = TRIG_POLARITY;
			in_d2 = TRIG_POLARITY;
			in_d3 = TRIG_POLARITY;
			for (int k = 0; k < NUM_TRIG_OUT; k++) begin
				sel_shadow[k] = MUXSEL_OFF;
				sel_d1[k] = MUXSEL_OFF;
				sel_d2[k] = MUXSEL_OFF;
				out_cnt[k] = 0;
			end
			for (int i = 0; i < NUM_TRIG_IN; i++)
				in_cnt[i] = 0;
			exp_out_prev = '0;
			relay_left = 0;
			compare("trig_out", 32'd0, 32'(trig_out));
			compare("relay_a", 32'd0, 32'(relay_a));
			compare("relay_b", 32'd0, 32'(relay_b));
			compare("trig_in_led", 32'd0, 32'(trig_in_led));
			compare("trig_out_led", 32'd0, 32'(trig_out_led));
			compare("prdata", 32'd0, prdata);
			compare("pslverr", 32'd0, 32'(pslverr));
		end else begin
			access = psel && penable;
			idx = sel_index(paddr);
			mapped = (idx >= 0) || (paddr == REG_RELAY_TOGGLE) ||
				(paddr == REG_RELAY_STATUS) || (paddr == REG_TRIG_STATUS);
			busy_exp = (relay_left > 0);
			//Corrected inputs now and one cycle back
			sync_now = in_d2 ^ TRIG_POLARITY;
			sync_prev = in_d3 ^ TRIG_POLARITY;

			//Routing, three cycles behind the pins
			exp_out = route_ref(in_d3, sel_d2);
			compare("trig_out", 32'(exp_out), 32'(trig_out));

			ra_exp = '0;
			rb_exp = '0;
			if (busy_exp) begin
				if (relay_dir)
					ra_exp[relay_chan] = 1'b1;
				else
					rb_exp[relay_chan] = 1'b1;
			end
			compare("relay_a", 32'(ra_exp), 32'(relay_a));
			compare("relay_b", 32'(rb_exp), 32'(relay_b));

			//Stretch windows
			for (int i = 0; i < NUM_TRIG_IN; i++) begin
				if (sync_prev[i])
					in_cnt[i] = LED_STRETCH_CYCLES;
				else if (in_cnt[i] > 0)
					in_cnt[i]--;
				in_led_exp[i] = (in_cnt[i] != 0);
			end
			for (int k = 0; k < NUM_TRIG_OUT; k++) begin
				if (exp_out_prev[k])
					out_cnt[k] = LED_STRETCH_CYCLES;
				else if (out_cnt[k] > 0)
					out_cnt[k]--;
				out_led_exp[k] = (out_cnt[k] != 0);
			end
			compare("trig_in_led", 32'(in_led_exp), 32'(trig_in_led));
			compare("trig_out_led", 32'(out_led_exp), 32'(trig_out_led));

			//APB read data and response
			rd_exp = '0;
			if (access && !pwrite) begin
				if (idx >= 0)
					rd_exp = 32'(sel_shadow[idx]);
				else if (paddr == REG_RELAY_STATUS)
					rd_exp = 32'(busy_exp);
				else if (paddr == REG_TRIG_STATUS)
					rd_exp = 32'(sync_now);
			end
			compare("prdata", rd_exp, prdata);
			if (access) begin
				compare("pready", 32'd1, 32'(pready));
				compare("pslverr",
					32'(!mapped || (pwrite && paddr == REG_RELAY_TOGGLE && busy_exp)),
					32'(pslverr));
			end else
				compare("pslverr", 32'd0, 32'(pslverr));

			//Advance the model
			if (access && pwrite && idx >= 0)
				sel_shadow[idx] = muxsel_t'(pwdata[3:0]);
			if (access && pwrite && paddr == REG_RELAY_TOGGLE && !busy_exp) begin
				relay_left = RELAY_PULSE_CYCLES;
				relay_dir = pwdata[TOGGLE_DIR_BIT];
				relay_chan = pwdata[TOGGLE_CHAN_LSB +: 2];
			end else if (relay_left > 0)
				relay_left--;
			exp_out_prev = exp_out;
			sel_d2 = sel_d1;
			sel_d1 = sel_shadow;
			in_d3 = in_d2;
			in_d2 = in_d1;
			in_d1 = trig_in;
		end
	end

endmodule

// ==== tb/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import crossbar_pkg::*, regmap_pkg::*; ();

	//Short pulse and hold times keep the run small
	localparam trig_vec_t	TRIG_POLARITY		= TRIG_POLARITY_DEFAULT;
	localparam int			RELAY_PULSE_CYCLES	= 20;
	localparam int			LED_STRETCH_CYCLES	= 16;
	localparam int			CLK_PERIOD			= 20;
	localparam int			ROUTE_ITERS			= 40;

	//Sum of the test lengths, doubled as margin
	localparam int WATCHDOG_CYCLES = 2 * (5 + 40 + 24 + ROUTE_ITERS * 14 + 80 +
		8 * (RELAY_PULSE_CYCLES + 16) + 3 * LED_STRETCH_CYCLES + 40);

	logic		clk_250mhz = 1'b0;
	logic		arst_n;
	logic		psel;
	logic		penable;
	logic		pwrite;
	apb_addr_t	paddr;
	apb_data_t	pwdata;
	apb_data_t	prdata;
	logic		pready;
	logic		pslverr;
	trig_vec_t	trig_in;
	trig_vec_t	trig_out;
	relay_vec_t	relay_a;
	relay_vec_t	relay_b;
	trig_vec_t	trig_in_led;
	trig_vec_t	trig_out_led;

	int			check_errors;
	int			wait_failures;
	int			tests_done;
	int			last_total;

	always #(CLK_PERIOD / 2) clk_250mhz = ~clk_250mhz;

	//////////////////////////////
	// DUT and checker

	trigger_crossbar_top #(
		.TRIG_POLARITY(TRIG_POLARITY),
		.RELAY_PULSE_CYCLES(RELAY_PULSE_CYCLES),
		.LED_STRETCH_CYCLES(LED_STRETCH_CYCLES)
	) uut (
		.clk_250mhz(clk_250mhz), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.trig_in(trig_in), .trig_out(trig_out),
		.relay_a(relay_a), .relay_b(relay_b),
		.trig_in_led(trig_in_led), .trig_out_led(trig_out_led)
	);

	tb_checker #(
		.TRIG_POLARITY(TRIG_POLARITY),
		.RELAY_PULSE_CYCLES(RELAY_PULSE_CYCLES),
		.LED_STRETCH_CYCLES(LED_STRETCH_CYCLES)
	) chk (
		.clk_250mhz(clk_250mhz), .arst_n(arst_n),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
		.prdata(prdata), .pready(pready), .pslverr(pslverr),
		.trig_in(trig_in), .trig_out(trig_out),
		.relay_a(relay_a), .relay_b(relay_b),
		.trig_in_led(trig_in_led), .trig_out_led(trig_out_led),
		.error_count(check_errors)
	);

	//////////////////////////////
	// Bus and wait helpers

	//Setup then access phase, starts and ends 2 ns after a rising edge
	task automatic transfer(input logic is_write, input apb_addr_t addr, input apb_data_t data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = is_write;
		paddr = addr;
		pwdata = is_write ? data : '0;
		@(posedge clk_250mhz);
		#2;
		penable = 1'b1;
		@(posedge clk_250mhz);
		#2;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) begin
			@(posedge clk_250mhz);
			#2;
		end
	endtask

	function automatic apb_addr_t sel_addr(input int k);
		return apb_addr_t'(int'(REG_MUXSEL_BASE) + REG_MUXSEL_STRIDE * k);
	endfunction

	//Poll until the relay lines drop, bounded
	task automatic settle_relays();
		int	n;
		n = 0;
		while ((relay_a | relay_b) != '0 && n < RELAY_PULSE_CYCLES + 10) begin
			wait_cycles(1);
			n++;
		end
		if ((relay_a | relay_b) != '0) begin
			wait_failures++;
			$display("relay pulse still active after %0d cycles", n);
		end
	endtask

	//Poll until any LED is lit or until all are dark
	task automatic wait_leds(input logic lit, input int limit);
		int	n;
		n = 0;
		while (((trig_in_led | trig_out_led) != '0) != lit && n < limit) begin
			wait_cycles(1);
			n++;
		end
		if (((trig_in_led | trig_out_led) != '0) != lit) begin
			wait_failures++;
			$display("LEDs did not turn %s within %0d cycles", lit ? "on" : "off", limit);
		end
	endtask

	task automatic finish_test(input string name);
		int	now_total;
		now_total = check_errors + wait_failures;
		tests_done++;
		$display("test %0d %s: %0d failures", tests_done, name, now_total - last_total);
		last_total = now_total;
	endtask

	//////////////////////////////
	// Stimulus

	initial begin : stimulus
		apb_data_t	cmd;
		arst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		trig_in = TRIG_POLARITY;
		wait_failures = 0;
		tests_done = 0;
		last_total = 0;
		void'($urandom(32'h583b_8145));
		repeat (5) @(posedge clk_250mhz);
		#2;
		arst_n = 1'b1;

		//Reset state and default selects
		wait_cycles(3);
		for (int k = 0; k < NUM_TRIG_OUT; k++)
			transfer(1'b0, sel_addr(k), '0);
		wait_cycles(4);
		finish_test("reset values");

		//Random selects, out of range ones too, and random pin patterns
		for (int k = 0; k < NUM_TRIG_OUT; k++)
			transfer(1'b1, sel_addr(k), apb_data_t'($urandom_range(15, 0)));
		for (int it = 0; it < ROUTE_ITERS; it++) begin
			transfer(1'b1, sel_addr(int'($urandom_range(NUM_TRIG_OUT - 1, 0))),
				apb_data_t'($urandom_range(15, 0)));
			repeat (3) begin
				trig_in = trig_vec_t'($urandom);
				wait_cycles(int'($urandom_range(4, 1)));
			end
		end
		wait_cycles(4);
		finish_test("random routing");

		//Readback, then status with pins held steady
		for (int k = 0; k < NUM_TRIG_OUT; k++) begin
			transfer(1'b1, sel_addr(k), apb_data_t'($urandom_range(15, 0)));
			transfer(1'b0, sel_addr(k), '0);
		end
		trig_in = trig_vec_t'($urandom);
		wait_cycles(3);
		transfer(1'b0, REG_TRIG_STATUS, '0);
		transfer(1'b0, REG_RELAY_STATUS, '0);
		transfer(1'b1, REG_TRIG_STATUS, 32'hffff_ffff);
		//Holes past the select window, misaligned and past the map
		transfer(1'b0, 8'h30, '0);
		transfer(1'b0, 8'h3c, '0);
		transfer(1'b0, 8'h02, '0);
		transfer(1'b0, 8'h4c, '0);
		transfer(1'b0, 8'hfc, '0);
		transfer(1'b1, 8'h80, 32'h0000_0005);
		wait_cycles(4);
		finish_test("register readback");

		//Each relay both ways, refused second toggle mid pulse
		for (int ch = 0; ch < NUM_RELAYS; ch++) begin
			for (int dir = 0; dir < 2; dir++) begin
				cmd = apb_data_t'((ch << TOGGLE_CHAN_LSB) | (dir << TOGGLE_DIR_BIT));
				transfer(1'b1, REG_RELAY_TOGGLE, cmd);
				transfer(1'b0, REG_RELAY_STATUS, '0);
				transfer(1'b1, REG_RELAY_TOGGLE, cmd ^ 32'h1);
				settle_relays();
				transfer(1'b0, REG_RELAY_STATUS, '0);
			end
		end
		wait_cycles(4);
		finish_test("relay toggle");

		//Single cycle pulse on a swapped input, routed to two outputs
		trig_in = TRIG_POLARITY;
		transfer(1'b1, sel_addr(0), 32'd5);
		transfer(1'b1, sel_addr(7), 32'd5);
		wait_leds(1'b0, LED_STRETCH_CYCLES + 10);
		trig_in = TRIG_POLARITY ^ trig_vec_t'(1 << 5);
		wait_cycles(1);
		trig_in = TRIG_POLARITY;
		wait_leds(1'b1, 10);
		wait_leds(1'b0, 2 * LED_STRETCH_CYCLES + 10);
		wait_cycles(4);
		finish_test("LED stretch");

		$display("%0d tests, %0d mismatches, %0d other failures",
			tests_done, check_errors, wait_failures);
		if (check_errors + wait_failures == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	//Hard stop if a test hangs
	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/crossbar_pkg.sv
hdl/regmap_pkg.sv
hdl/relay_cmd_if.sv
hdl/crossbar_matrix.sv
hdl/activity_led.sv
hdl/relay_controller.sv
hdl/crossbar_regs.sv
hdl/trigger_crossbar_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_PATTERN='>>> FAIL'

verilator --binary --timing -Wno-fatal --top-module tb_top \
	-f sources.f -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "$FAIL_PATTERN" "$LOG"; then
	exit 1
fi
exit 0
